// File: src.f
+incdir+.
dec_pkg.sv
dec_i_decoder.sv
dec_m_decoder.sv
dec_decoder.sv
dec_controller.sv
dec_top.sv
tb_dec_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode peripheral testbench with Verilator
# exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_dec_top --Mdir obj_dir -o tb_dec_top \
  -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_dec_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

// File: tb_dec_model.svh
////////////////////////////////////////////////////////////
// reference decode model, lfsr and instruction generator
// included inside the testbench module, uses its lfsr_q
////////////////////////////////////////////////////////////
`ifndef TB_DEC_MODEL_SVH
`define TB_DEC_MODEL_SVH

logic [31:0] lfsr_q = 32'hb4fb;  // fixed seed

// fibonacci lfsr, taps 32 22 2 1, one step per bit returned
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    r      = {r[30:0], fb};
  end
  return r;
endfunction

// shared funct3 table of OP and OP-IMM
function automatic alu_opcode_e alu_from_f3(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return alt ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

// lsu width from the low funct3 bits
function automatic logic [1:0] width_from_f3(input logic [2:0] f3);
  case (f3[1:0])
    2'd0:    return DT_BYTE;
    2'd1:    return DT_HALF;
    default: return DT_WORD;
  endcase
endfunction

// expected host word for one instruction, masked when a trap is pending
function automatic ctrl_word_t model_decode(input logic [31:0] ins, input logic masked);
  ctrl_word_t w;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       ok;
  w  = '0;
  f3 = ins[14:12];
  f7 = ins[31:25];
  ok = 1'b1;
  case (ins[6:0])
    OPCODE_LUI, OPCODE_AUIPC: {w.alu_en, w.rf_we} = 2'b11;
    OPCODE_JAL: begin
      {w.alu_en, w.rf_we}  = 2'b11;
      w.ctrl_transfer_insn = BRANCH_JAL;
    end
    OPCODE_JALR: begin
      {w.alu_en, w.rf_we}  = 2'b11;
      w.rf_re              = 2'b01;
      w.ctrl_transfer_insn = BRANCH_JALR;
      ok                   = (f3 == 3'd0);
    end
    OPCODE_BRANCH: begin
      w.alu_en             = 1'b1;
      w.rf_re              = 2'b11;
      w.ctrl_transfer_insn = BRANCH_COND;
      if (f3 == 3'd0) w.alu_operator = ALU_EQ;
      else if (f3 == 3'd1) w.alu_operator = ALU_NE;
      else w.alu_operator = f3[1] ? ALU_SLTU : ALU_SLT;
      ok = (f3[2:1] != 2'b01);  // funct3 2 and 3 unused
    end
    OPCODE_LOAD: begin
      {w.data_req, w.rf_we} = 2'b11;
      w.rf_re               = 2'b01;
      w.data_sign_ext       = !f3[2];
      w.data_type           = width_from_f3(f3);
      ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
    end
    OPCODE_STORE: begin
      {w.data_req, w.data_we} = 2'b11;
      w.rf_re                 = 2'b11;
      w.data_type             = width_from_f3(f3);
      ok                      = (f3 <= 3'd2);
    end
    OPCODE_OP_IMM: begin
      {w.alu_en, w.rf_we} = 2'b11;
      w.rf_re             = 2'b01;
      w.alu_operator      = alu_from_f3(f3, (f3 == 3'd5) && (f7 == FUNCT7_ALT));
      if (f3 == 3'd1) ok = (f7 == 7'd0);
      if (f3 == 3'd5) ok = (f7 == 7'd0) || (f7 == FUNCT7_ALT);
    end
    OPCODE_OP: begin
      w.rf_we = 1'b1;
      w.rf_re = 2'b11;
      if (f7 == FUNCT7_M) begin  // multiply / divide
        w.mult_en       = 1'b1;
        w.mult_operator = mul_opcode_e'(f3);
      end else begin
        w.alu_en       = 1'b1;
        w.alu_operator = alu_from_f3(f3, f7 == FUNCT7_ALT);
        ok = (f7 == 7'd0) || ((f7 == FUNCT7_ALT) && ((f3 == 3'd0) || (f3 == 3'd5)));
      end
    end
    OPCODE_MISC_MEM: begin
      w.fencei_insn = 1'b1;
      ok            = (f3 == 3'd1);
    end
    OPCODE_SYSTEM: begin
      w.ecall_insn = (ins == INSTR_ECALL);
      w.ebrk_insn  = (ins == INSTR_EBRK);
      w.mret_insn  = (ins == INSTR_MRET);
      w.wfi_insn   = (ins == INSTR_WFI);
      ok = w.ecall_insn | w.ebrk_insn | w.mret_insn | w.wfi_insn;
    end
    default: ok = 1'b0;
  endcase
  if (!ok) begin
    w              = '0;
    w.illegal_insn = 1'b1;
  end
  if (masked) begin  // side effects off, decode flags stay
    {w.alu_en, w.mult_en, w.rf_we, w.data_req, w.data_we} = 5'b0;
    w.ctrl_transfer_insn = BRANCH_NONE;
  end
  return w;
endfunction

// random word, biased toward real opcodes and useful funct7 values
function automatic logic [31:0] gen_instr();
  logic [31:0] w;
  w = rand_bits(32);
  case (rand_bits(2))
    0:       w[31:25] = 7'b0000000;
    1:       w[31:25] = FUNCT7_ALT;
    2:       w[31:25] = FUNCT7_M;
    default: ;  // keep the random funct7
  endcase
  case (rand_bits(4))
    0:  w[6:0] = OPCODE_LUI;
    1:  w[6:0] = OPCODE_AUIPC;
    2:  w[6:0] = OPCODE_JAL;
    3:  w[6:0] = OPCODE_JALR;
    4:  w[6:0] = OPCODE_BRANCH;
    5:  w[6:0] = OPCODE_LOAD;
    6:  w[6:0] = OPCODE_STORE;
    7:  w[6:0] = OPCODE_OP_IMM;
    8, 9, 10: w[6:0] = OPCODE_OP;  // extra weight, hits M often
    11: w[6:0] = OPCODE_SYSTEM;   // mostly illegal csr space
    12: begin
      case (rand_bits(2))
        0:       w = INSTR_ECALL;
        1:       w = INSTR_EBRK;
        2:       w = INSTR_MRET;
        default: w = INSTR_WFI;
      endcase
    end
    13: begin
      w[6:0]   = OPCODE_MISC_MEM;
      w[14:12] = 3'b001;  // fence.i
    end
    default: ;  // fully random word
  endcase
  return w;
endfunction

`endif

// File: tb_dec_top.sv
////////////////////////////////////////////////////////////
// testbench for dec_top, directed and random decode checks
// one bus transfer at a time, first error ends the run
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_dec_top import dec_pkg::*; ();

  localparam int N_RANDOM       = 2000;
  localparam int ITEM_CYCLES    = 16;  // write, two reads, optional status write
  localparam int TIMEOUT_CYCLES = (N_RANDOM + 200) * ITEM_CYCLES;
  localparam logic [3:0] A_INSTR  = {ADDR_INSTR, 2'b00};
  localparam logic [3:0] A_STATUS = {ADDR_STATUS, 2'b00};

  logic        clk_i;
  logic        rst_n_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  logic [3:0]  adr_i;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic        ack_o;
  logic        trap_o;

  logic        model_trap;    // expected sticky flag
  ctrl_word_t  model_result;  // expected result register
  logic [31:0] last_instr;
  int          cycle_cnt = 0;
  logic [31:0] legal_list [0:18];
  logic [31:0] trap_list [0:2];

  `include "tb_dec_model.svh"

  dec_top uut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o),
    .trap_o  (trap_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      halt_with_failure();
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic halt_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input ctrl_word_t got, input ctrl_word_t exp, input logic [31:0] ins);
    if (got !== exp) begin
      $display("MISMATCH time %0t: result for instr %h is %h, expected %h", $time, ins, got, exp);
      halt_with_failure();
    end
  endtask

  task automatic check_status(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH time %0t: %s is %b, expected %b", $time, what, got, exp);
      halt_with_failure();
    end
  endtask

  // raw bus words, reset values and unmapped reads
  task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH time %0t: %s is %h, expected %h", $time, what, got, exp);
      halt_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // wishbone master
  ////////////////////////////////////////////////////////////

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= 1'b1;
    adr_i <= adr;
    dat_i <= dat;
    do @(negedge clk_i); while (!ack_o);  // global watchdog bounds this
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk_i);
    check_status(ack_o, 1'b0, "ack_o one cycle after write ack");  // single-cycle ack
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= 1'b0;
    adr_i <= adr;
    do @(negedge clk_i); while (!ack_o);
    dat = dat_o;  // valid in the ack cycle
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    @(negedge clk_i);
    check_status(ack_o, 1'b0, "ack_o one cycle after read ack");
  endtask

  ////////////////////////////////////////////////////////////
  // test items
  ////////////////////////////////////////////////////////////

  task automatic verify_result();
    logic [31:0] rd;
    wb_read(A_INSTR, rd);
    check_word(ctrl_word_t'(rd), model_result, last_instr);
  endtask

  task automatic verify_status();
    logic [31:0] rd;
    wb_read(A_STATUS, rd);
    check_status(rd[0], model_trap, "status bit 0");
    check_data({rd[31:1], 1'b0}, 32'h0, "status upper bits");
    @(negedge clk_i);
    check_status(trap_o, model_trap, "trap_o");
  endtask

  task automatic write_status(input logic [31:0] d);
    wb_write(A_STATUS, d);
    if (d[0]) model_trap = 1'b0;  // only bit 0 clears
  endtask

  // mask uses the flag from before this write
  task automatic run_item(input logic [31:0] ins);
    ctrl_word_t exp;
    exp = model_decode(ins, model_trap);
    wb_write(A_INSTR, ins);
    last_instr   = ins;
    model_result = exp;
    if (exp.illegal_insn || exp.ebrk_insn || exp.ecall_insn) model_trap = 1'b1;
    verify_result();
    verify_status();
  endtask

  initial begin
    logic [31:0] rd;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    cyc_i        = 1'b0;
    stb_i        = 1'b0;
    we_i         = 1'b0;
    adr_i        = '0;
    dat_i        = '0;
    model_trap   = 1'b0;
    model_result = '0;
    last_instr   = INSTR_NOP;
    legal_list   = '{32'h0051_0093, 32'h0020_81b3, 32'h4020_81b3, 32'h4073_52b3,
                     32'h0030_9093, 32'h4030_d093, 32'h1234_50b7, 32'h0000_1117,
                     32'h0080_00ef, 32'h0001_00e7, 32'h0020_8463, 32'h0020_e463,
                     32'h0001_2083, 32'h0001_5083, 32'h0001_0083, 32'h0011_2023,
                     32'h0011_0023, 32'h0000_100f, INSTR_MRET};
    trap_list    = '{INSTR_EBRK, INSTR_ECALL, 32'h0000_0000};

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // reset state
    wb_read(A_INSTR, rd);
    check_data(rd, 32'h0, "result word after reset");
    wb_read(A_STATUS, rd);
    check_data(rd, 32'h0, "status word after reset");
    @(negedge clk_i);
    check_status(trap_o, 1'b0, "trap_o after reset");

    // legal I subset, flag cleared before each
    foreach (legal_list[i]) begin
      write_status(32'h1);
      run_item(legal_list[i]);
    end
    write_status(32'h1);
    run_item(INSTR_WFI);

    // every M funct3, then a foreign funct7 on OP
    for (int k = 0; k < 8; k++) begin
      run_item({FUNCT7_M, 5'd2, 5'd1, k[2:0], 5'd3, OPCODE_OP});
    end
    run_item({7'b0000010, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP});
    write_status(32'h1);

    // trap sources, masking and release
    foreach (trap_list[i]) begin
      write_status(32'h1);
      verify_status();
      run_item(trap_list[i]);
      run_item(32'h0020_81b3);  // add
      run_item(32'h0011_2023);  // sw
      run_item(32'h0220_8133);  // mul
      run_item(32'h0080_00ef);  // jal
      write_status(32'h0);      // no clear without bit 0
      verify_status();
      write_status(32'h1);
      verify_status();
      run_item(32'h0020_81b3);
    end

    // unmapped space with the flag set
    run_item(INSTR_EBRK);
    wb_write(4'h8, rand_bits(32));
    wb_write(4'hc, 32'hffff_ffff);  // would clear the flag if it hit status
    wb_write(4'h1, 32'h0020_81b3);  // byte offset, not the instr reg
    wb_write(4'h6, 32'hffff_ffff);  // not the status reg
    verify_result();
    verify_status();
    wb_read(4'h8, rd);
    check_data(rd, 32'h0, "read of address 8");
    wb_read(4'hc, rd);
    check_data(rd, 32'h0, "read of address c");
    wb_read(4'h1, rd);
    check_data(rd, 32'h0, "read of address 1");
    write_status(32'h1);
    verify_status();

    // random words with random status writes mixed in
    for (int n = 0; n < N_RANDOM; n++) begin
      run_item(gen_instr());
      if (rand_bits(2) == 0) begin
        write_status(rand_bits(32));
        verify_status();
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: dec_top.sv
////////////////////////////////////////////////////////////
// decode peripheral top, wishbone classic slave port
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dec_top import dec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [3:0]  adr_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        trap_o
);

  logic [31:0] instr;
  logic        trap_mask;
  ctrl_word_t  ctrl_word;
  logic        trap_hit;

  dec_controller controller_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .ctrl_word_i (ctrl_word),
    .trap_hit_i  (trap_hit),
    .ack_o       (ack_o),
    .dat_o       (dat_o),
    .trap_o      (trap_o),
    .instr_o     (instr),
    .trap_mask_o (trap_mask)
  );

  dec_decoder decoder_i (
    .instr_i     (instr),
    .trap_mask_i (trap_mask),
    .ctrl_word_o (ctrl_word),
    .trap_hit_o  (trap_hit)
  );

endmodule

// File: dec_controller.sv
////////////////////////////////////////////////////////////
// wishbone classic slave, never stalls, one ack per strobe
// master must drop stb after ack, adr held through ack cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dec_controller import dec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [3:0]  adr_i,
  input  logic [31:0] dat_i,
  input  ctrl_word_t  ctrl_word_i,   // decode of instr_o
  input  logic        trap_hit_i,
  output logic        ack_o,
  output logic [31:0] dat_o,
  output logic        trap_o,
  output logic [31:0] instr_o,
  output logic        trap_mask_o
);

  wb_state_e   state_q;
  logic        req;
  logic        sel_instr;
  logic        sel_status;
  logic        instr_wr;
  logic        status_clr;
  logic [31:0] instr_q;
  ctrl_word_t  result_q;
  logic        trap_q;

  assign req        = (state_q == WB_IDLE) && cyc_i && stb_i;
  // byte offsets other than 0 fall into the unmapped space
  assign sel_instr  = (adr_i[1:0] == 2'b00) && (adr_i[3:2] == ADDR_INSTR);
  assign sel_status = (adr_i[1:0] == 2'b00) && (adr_i[3:2] == ADDR_STATUS);
  assign instr_wr   = req && we_i && sel_instr;
  assign status_clr = req && we_i && sel_status && dat_i[0];

  ////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= WB_IDLE;
    end else begin
      case (state_q)
        WB_IDLE: if (req) state_q <= WB_ACK;
        default: state_q <= WB_IDLE;  // ack lasts one cycle
      endcase
    end
  end

  assign ack_o = (state_q == WB_ACK);

  // new word goes straight to the decoder so the result loads with it
  assign instr_o = instr_wr ? dat_i : instr_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_q  <= INSTR_NOP;
      result_q <= '0;
    end else if (instr_wr) begin
      instr_q  <= dat_i;
      result_q <= ctrl_word_i;
    end
  end

  // sticky trap, cleared only by the host
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trap_q <= 1'b0;
    end else if (status_clr) begin
      trap_q <= 1'b0;
    end else if (instr_wr && trap_hit_i) begin
      trap_q <= 1'b1;
    end
  end

  assign trap_o      = trap_q;
  assign trap_mask_o = trap_q;  // masks decode of later writes

  // read mux, address still valid in the ack cycle
  always_comb begin
    dat_o = '0;
    if (sel_instr) begin
      dat_o = result_q;
    end else if (sel_status) begin
      dat_o = {31'b0, trap_q};
    end
  end

  ////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////

  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o |=> !ack_o);

  a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(cyc_i && stb_i));

endmodule

// File: dec_decoder.sv
////////////////////////////////////////////////////////////
// merges sub-decoder bundles, M match wins over I
// trap_mask_i kills side effects, decode flags stay visible
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dec_decoder import dec_pkg::*; (
  input  logic [31:0] instr_i,
  input  logic        trap_mask_i,   // sticky trap pending
  output ctrl_word_t  ctrl_word_o,
  output logic        trap_hit_o     // from the unmasked bundle
);

  decoder_ctrl_t i_ctrl;
  decoder_ctrl_t m_ctrl;
  decoder_ctrl_t mux_ctrl;

  dec_i_decoder i_decoder_i (
    .instr_i        (instr_i),
    .decoder_ctrl_o (i_ctrl)
  );

  dec_m_decoder m_decoder_i (
    .instr_i        (instr_i),
    .decoder_ctrl_o (m_ctrl)
  );

  // priority select, illegal when nobody claims the word
  always_comb begin
    if (!m_ctrl.illegal_insn) begin
      mux_ctrl = m_ctrl;
    end else if (!i_ctrl.illegal_insn) begin
      mux_ctrl = i_ctrl;
    end else begin
      mux_ctrl = DECODER_CTRL_ILLEGAL_INSN;
    end
  end

  assign trap_hit_o = mux_ctrl.illegal_insn | mux_ctrl.ebrk_insn | mux_ctrl.ecall_insn;

  ////////////////////////////////////////////////////////////
  // mask and pack
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_word_o                    = '0;
    ctrl_word_o.rf_re              = mux_ctrl.rf_re;
    ctrl_word_o.mult_operator      = mux_ctrl.mult_operator;
    ctrl_word_o.alu_operator       = mux_ctrl.alu_operator;
    ctrl_word_o.ctrl_transfer_insn = trap_mask_i ? BRANCH_NONE : mux_ctrl.ctrl_transfer_insn;
    ctrl_word_o.data_sign_ext      = mux_ctrl.data_sign_ext;
    ctrl_word_o.data_type          = mux_ctrl.data_type;
    ctrl_word_o.data_we            = mux_ctrl.data_we  & ~trap_mask_i;
    ctrl_word_o.data_req           = mux_ctrl.data_req & ~trap_mask_i;
    ctrl_word_o.rf_we              = mux_ctrl.rf_we    & ~trap_mask_i;
    ctrl_word_o.mult_en            = mux_ctrl.mult_en  & ~trap_mask_i;
    ctrl_word_o.alu_en             = mux_ctrl.alu_en   & ~trap_mask_i;
    ctrl_word_o.fencei_insn        = mux_ctrl.fencei_insn;
    ctrl_word_o.wfi_insn           = mux_ctrl.wfi_insn;
    ctrl_word_o.mret_insn          = mux_ctrl.mret_insn;
    ctrl_word_o.ecall_insn         = mux_ctrl.ecall_insn;
    ctrl_word_o.ebrk_insn          = mux_ctrl.ebrk_insn;
    ctrl_word_o.illegal_insn       = mux_ctrl.illegal_insn;
  end

  // opcode spaces of I and M must stay disjoint
  always_comb begin
    assert (i_ctrl.illegal_insn || m_ctrl.illegal_insn)
      else $error("i and m decoders both claim instr %h", instr_i);
  end

endmodule

// File: dec_m_decoder.sv
////////////////////////////////////////////////////////////
// RV32M decoder, matches OP with funct7 0000001 only
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dec_m_decoder import dec_pkg::*; (
  input  logic [31:0]   instr_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;  // no match by default
    if ((opcode_e'(instr_i[6:0]) == OPCODE_OP) && (instr_i[31:25] == FUNCT7_M)) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.mult_en      = 1'b1;
      decoder_ctrl_o.rf_we        = 1'b1;
      decoder_ctrl_o.rf_re        = 2'b11;  // rs1 and rs2
      case (instr_i[14:12])
        3'b000:  decoder_ctrl_o.mult_operator = MUL_MUL;
        3'b001:  decoder_ctrl_o.mult_operator = MUL_MULH;
        3'b010:  decoder_ctrl_o.mult_operator = MUL_MULHSU;
        3'b011:  decoder_ctrl_o.mult_operator = MUL_MULHU;
        3'b100:  decoder_ctrl_o.mult_operator = MUL_DIV;
        3'b101:  decoder_ctrl_o.mult_operator = MUL_DIVU;
        3'b110:  decoder_ctrl_o.mult_operator = MUL_REM;
        default: decoder_ctrl_o.mult_operator = MUL_REMU;
      endcase
    end
  end

endmodule

// File: dec_i_decoder.sv
////////////////////////////////////////////////////////////
// RV32I subset decoder, purely combinational
// OP with funct7 0000001 is left to the M decoder
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dec_i_decoder import dec_pkg::*; (
  input  logic [31:0]   instr_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          illegal;
  decoder_ctrl_t ctrl;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    ctrl              = DECODER_CTRL_ILLEGAL_INSN;
    ctrl.illegal_insn = 1'b0;
    illegal           = 1'b0;

    case (opcode_e'(instr_i[6:0]))
      OPCODE_LUI, OPCODE_AUIPC: begin
        ctrl.alu_en = 1'b1;  // imm or pc + imm
        ctrl.rf_we  = 1'b1;
      end
      OPCODE_JAL: begin
        ctrl.ctrl_transfer_insn = BRANCH_JAL;
        ctrl.alu_en             = 1'b1;  // link address
        ctrl.rf_we              = 1'b1;
      end
      OPCODE_JALR: begin
        ctrl.ctrl_transfer_insn = BRANCH_JALR;
        ctrl.alu_en             = 1'b1;
        ctrl.rf_we              = 1'b1;
        ctrl.rf_re              = 2'b01;
        illegal                 = (funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        ctrl.ctrl_transfer_insn = BRANCH_COND;
        ctrl.alu_en             = 1'b1;
        ctrl.rf_re              = 2'b11;
        case (funct3)
          3'b000:         ctrl.alu_operator = ALU_EQ;
          3'b001:         ctrl.alu_operator = ALU_NE;
          3'b100, 3'b101: ctrl.alu_operator = ALU_SLT;   // blt / bge
          3'b110, 3'b111: ctrl.alu_operator = ALU_SLTU;  // bltu / bgeu
          default:        illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        ctrl.data_req      = 1'b1;
        ctrl.rf_we         = 1'b1;
        ctrl.rf_re         = 2'b01;
        ctrl.data_sign_ext = ~funct3[2];  // lbu / lhu zero extend
        case (funct3)
          3'b000, 3'b100: ctrl.data_type = DT_BYTE;
          3'b001, 3'b101: ctrl.data_type = DT_HALF;
          3'b010:         ctrl.data_type = DT_WORD;
          default:        illegal = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        ctrl.data_req = 1'b1;
        ctrl.data_we  = 1'b1;
        ctrl.rf_re    = 2'b11;
        case (funct3)
          3'b000:  ctrl.data_type = DT_BYTE;
          3'b001:  ctrl.data_type = DT_HALF;
          3'b010:  ctrl.data_type = DT_WORD;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b01;
        case (funct3)
          3'b000: ctrl.alu_operator = ALU_ADD;
          3'b010: ctrl.alu_operator = ALU_SLT;
          3'b011: ctrl.alu_operator = ALU_SLTU;
          3'b100: ctrl.alu_operator = ALU_XOR;
          3'b110: ctrl.alu_operator = ALU_OR;
          3'b111: ctrl.alu_operator = ALU_AND;
          3'b001: begin
            ctrl.alu_operator = ALU_SLL;
            illegal           = (funct7 != 7'b0000000);  // shamt[5] or junk
          end
          default: begin  // 3'b101
            ctrl.alu_operator = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
            illegal           = (funct7 != 7'b0000000) && (funct7 != FUNCT7_ALT);
          end
        endcase
      end
      OPCODE_OP: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b11;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl.alu_operator = ALU_ADD;
          {FUNCT7_ALT, 3'b000}: ctrl.alu_operator = ALU_SUB;
          {7'b0000000, 3'b001}: ctrl.alu_operator = ALU_SLL;
          {7'b0000000, 3'b010}: ctrl.alu_operator = ALU_SLT;
          {7'b0000000, 3'b011}: ctrl.alu_operator = ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl.alu_operator = ALU_XOR;
          {7'b0000000, 3'b101}: ctrl.alu_operator = ALU_SRL;
          {FUNCT7_ALT, 3'b101}: ctrl.alu_operator = ALU_SRA;
          {7'b0000000, 3'b110}: ctrl.alu_operator = ALU_OR;
          {7'b0000000, 3'b111}: ctrl.alu_operator = ALU_AND;
          default:              illegal = 1'b1;  // incl. FUNCT7_M
        endcase
      end
      OPCODE_MISC_MEM: begin
        ctrl.fencei_insn = 1'b1;
        illegal          = (funct3 != 3'b001);  // plain fence not supported
      end
      OPCODE_SYSTEM: begin
        // only exact encodings, csr space is not decoded
        ctrl.ecall_insn = (instr_i == INSTR_ECALL);
        ctrl.ebrk_insn  = (instr_i == INSTR_EBRK);
        ctrl.mret_insn  = (instr_i == INSTR_MRET);
        ctrl.wfi_insn   = (instr_i == INSTR_WFI);
        illegal         = ~(ctrl.ecall_insn | ctrl.ebrk_insn | ctrl.mret_insn | ctrl.wfi_insn);
      end
      default: illegal = 1'b1;
    endcase

    decoder_ctrl_o = illegal ? DECODER_CTRL_ILLEGAL_INSN : ctrl;  // clean bundle on miss
  end

endmodule

// File: dec_pkg.sv
////////////////////////////////////////////////////////////
// shared types and constants for the RV32 decode peripheral
// result word bit order is fixed, host software depends on it
////////////////////////////////////////////////////////////

package dec_pkg;

  ////////////////////////////////////////////////////////////
  // instruction encodings
  ////////////////////////////////////////////////////////////

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPCODE_LUI      = 7'h37,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_JAL      = 7'h6f,
    OPCODE_JALR     = 7'h67,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_LOAD     = 7'h03,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_OP       = 7'h33,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_SLL  = 5'h02,
    ALU_SLT  = 5'h03,
    ALU_SLTU = 5'h04,
    ALU_XOR  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    ALU_OR   = 5'h08,
    ALU_AND  = 5'h09,
    ALU_EQ   = 5'h0a,  // beq
    ALU_NE   = 5'h0b   // bne
  } alu_opcode_e;

  // same order as funct3 of the M extension
  typedef enum logic [2:0] {
    MUL_MUL    = 3'd0,
    MUL_MULH   = 3'd1,
    MUL_MULHSU = 3'd2,
    MUL_MULHU  = 3'd3,
    MUL_DIV    = 3'd4,
    MUL_DIVU   = 3'd5,
    MUL_REM    = 3'd6,
    MUL_REMU   = 3'd7
  } mul_opcode_e;

  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_COND = 2'b01,  // conditional branch
    BRANCH_JAL  = 2'b10,
    BRANCH_JALR = 2'b11
  } branch_e;

  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_ACK  = 1'b1
  } wb_state_e;

  localparam logic [6:0]  FUNCT7_M    = 7'b0000001;  // M extension on OP
  localparam logic [6:0]  FUNCT7_ALT  = 7'b0100000;  // sub / sra
  localparam logic [1:0]  DT_WORD     = 2'b00;       // lsu data_type
  localparam logic [1:0]  DT_HALF     = 2'b01;
  localparam logic [1:0]  DT_BYTE     = 2'b10;
  localparam logic [31:0] INSTR_NOP   = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
  localparam logic [31:0] INSTR_EBRK  = 32'h0010_0073;
  localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;
  localparam logic [31:0] INSTR_WFI   = 32'h1050_0073;

  // register map, word index on adr[3:2]
  localparam logic [1:0]  ADDR_INSTR  = 2'd0;
  localparam logic [1:0]  ADDR_STATUS = 2'd1;

  ////////////////////////////////////////////////////////////
  // control bundle and result word
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        illegal_insn;
    logic        ebrk_insn;
    logic        ecall_insn;
    logic        mret_insn;
    logic        wfi_insn;
    logic        fencei_insn;
    logic        alu_en;
    alu_opcode_e alu_operator;
    logic        mult_en;
    mul_opcode_e mult_operator;
    logic        rf_we;
    logic [1:0]  rf_re;          // bit 0 rs1, bit 1 rs2
    logic        data_req;
    logic        data_we;
    logic [1:0]  data_type;
    logic        data_sign_ext;
    branch_e     ctrl_transfer_insn;
  } decoder_ctrl_t;

  // no-match bundle, every side effect off
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn       : 1'b1,
    ebrk_insn          : 1'b0,
    ecall_insn         : 1'b0,
    mret_insn          : 1'b0,
    wfi_insn           : 1'b0,
    fencei_insn        : 1'b0,
    alu_en             : 1'b0,
    alu_operator       : ALU_ADD,
    mult_en            : 1'b0,
    mult_operator      : MUL_MUL,
    rf_we              : 1'b0,
    rf_re              : 2'b00,
    data_req           : 1'b0,
    data_we            : 1'b0,
    data_type          : DT_WORD,
    data_sign_ext      : 1'b0,
    ctrl_transfer_insn : BRANCH_NONE
  };

  // host-visible word, msb first
  typedef struct packed {
    logic [5:0]  pad;            // reads as zero, fills the word to 32 bits
    logic [1:0]  rf_re;
    mul_opcode_e mult_operator;
    alu_opcode_e alu_operator;
    branch_e     ctrl_transfer_insn;
    logic        data_sign_ext;
    logic [1:0]  data_type;
    logic        data_we;
    logic        data_req;
    logic        rf_we;
    logic        mult_en;
    logic        alu_en;
    logic        fencei_insn;
    logic        wfi_insn;
    logic        mret_insn;
    logic        ecall_insn;
    logic        ebrk_insn;
    logic        illegal_insn;
  } ctrl_word_t;

endpackage
